// ==== mem_share.f ====
source/mem_share_pkg.sv
source/rr_arbiter.sv
source/port_ingress.sv
source/shared_ram.sv
source/mem_share_top.sv
test/tb_mem_share.sv

// ==== Bender.yml ====
package:
  name: mem_share

sources:
  - source/mem_share_pkg.sv
  - source/rr_arbiter.sv
  - source/port_ingress.sv
  - source/shared_ram.sv
  - source/mem_share_top.sv
  - target: test
    files:
      - test/tb_mem_share.sv

// ==== test/tb_mem_share.sv ====
module tb_mem_share
	import mem_share_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int max_rows = 128;
	localparam int fair_rsps = 2 * n_ports; // two reads per port in the fairness burst.
	localparam int region_words = mem_words / n_ports;

	typedef struct packed {
		logic [15:0] cycle; // earliest issue cycle after reset.
		port_idx_t port;
		opcode_e op;
		logic [addr_w-1:0] addr;
		logic [tag_w-1:0] tag;
		logic [data_w-1:0] data;
		logic rnd; // data drawn from the lfsr at issue.
		logic sync; // wait until every port is idle first.
	} stim_row_t;

	typedef struct packed {
		port_idx_t port;
		logic [tag_w-1:0] tag;
		logic [data_w-1:0] data;
	} exp_rsp_t;

	logic aclk;
	logic aresetn;
	logic [n_ports-1:0] cmd_valid;
	opcode_e cmd_op [n_ports];
	cmd_payload_u cmd_payload [n_ports];
	logic [n_ports-1:0] credit_return;
	logic rsp_valid;
	port_idx_t rsp_port;
	logic [tag_w-1:0] rsp_tag;
	logic [data_w-1:0] rsp_data;

	stim_row_t table_rows [max_rows];
	int n_rows;
	logic table_ready;
	logic [31:0] lfsr;

	logic [data_w-1:0] ref_mem [mem_words];
	exp_rsp_t exp_q [$];

	int credits [n_ports];
	int issued [n_ports];
	int returned [n_ports];
	int stalls [n_ports];
	logic issued_any;
	int rsp_count;
	int last_rsp_cycle;
	int neg_cycle;

	mem_share_top i_dut (
		.aclk (aclk),
		.aresetn (aresetn),
		.cmd_valid (cmd_valid),
		.cmd_op (cmd_op),
		.cmd_payload (cmd_payload),
		.credit_return (credit_return),
		.rsp_valid (rsp_valid),
		.rsp_port (rsp_port),
		.rsp_tag (rsp_tag),
		.rsp_data (rsp_data)
	);

	initial begin : clock_gen
		aclk = 1'b0;
		forever begin
			#2 aclk = ~aclk;
		end
	end

	// ==========================================================================
	// helpers
	// ==========================================================================

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic expect_data(input string name, input logic [data_w-1:0] got,
			input logic [data_w-1:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic compare_tag(input string name, input logic [tag_w-1:0] got,
			input logic [tag_w-1:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic verify_port(input string name, input port_idx_t got, input port_idx_t exp);
		if (got !== exp) begin
			report_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic credits_match(input string name, input int got, input int exp);
		if (got != exp) begin
			report_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	// fibonacci lfsr, taps 32 22 2 1, one step per bit.
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] value;
		logic fb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	function automatic logic [addr_w-1:0] region(input int port, input int word);
		return addr_w'(port * region_words + word); // each port owns its own block.
	endfunction

	function automatic cmd_payload_u make_payload(input opcode_e op,
			input logic [addr_w-1:0] addr, input logic [tag_w-1:0] tag,
			input logic [data_w-1:0] data);
		cmd_payload_u p;
		p = '0;
		if (op == op_write) begin
			p.wr_view.addr = addr;
			p.wr_view.data = data;
		end else begin
			p.rd_view.addr = addr;
			p.rd_view.tag = tag;
		end
		return p;
	endfunction

	function automatic logic all_drained();
		logic done;
		done = (exp_q.size() == 0);
		for (int i = 0; i < n_ports; i++) begin
			if (credits[i] != fifo_depth) begin
				done = 1'b0;
			end
		end
		return done;
	endfunction

	// ==========================================================================
	// stimulus table
	// ==========================================================================

	task automatic add_row(input int cycle, input int port, input opcode_e op,
			input logic [addr_w-1:0] addr, input int tag, input logic [data_w-1:0] data,
			input logic rnd, input logic sync);
		stim_row_t r;
		r.cycle = 16'(cycle);
		r.port = port_idx_t'(port);
		r.op = op;
		r.addr = addr;
		r.tag = tag_w'(tag);
		r.data = data;
		r.rnd = rnd;
		r.sync = sync;
		table_rows[n_rows] = r;
		n_rows++;
	endtask

	task automatic build_table();
		int p;
		opcode_e op;
		n_rows = 0;
		for (int w = 0; w < 8; w++) begin
			for (int i = 0; i < n_ports; i++) begin
				add_row(3, i, op_write, region(i, w), 0, '0, 1'b1, 1'b0); // preload.
			end
		end
		// a lone grant to the top port wraps the mask to all ones.
		add_row(0, n_ports - 1, op_write, region(n_ports - 1, 63), 0, 32'h0bad_f00d,
			1'b0, 1'b1);
		for (int r = 0; r < 2; r++) begin
			for (int i = 0; i < n_ports; i++) begin
				add_row(0, i, op_read, region(i, r), 16 * (r + 1) + i, '0, 1'b0,
					(r == 0) && (i == 0)); // fairness burst.
			end
		end
		add_row(0, 2, op_write, region(2, 20), 0, 32'hcafe_0001, 1'b0, 1'b1);
		add_row(0, 1, op_write, region(1, 21), 0, 32'h1234_5678, 1'b0, 1'b0);
		add_row(0, 2, op_read, region(2, 20), 8'h5a, '0, 1'b0, 1'b0);
		add_row(0, 1, op_read, region(1, 21), 8'ha5, '0, 1'b0, 1'b0);
		for (int n = 0; n < fifo_depth + 2; n++) begin
			for (int i = 0; i < n_ports; i++) begin
				add_row(0, i, op_write, region(i, 32 + n), 0, '0, 1'b1,
					(n == 0) && (i == 0)); // more than the credits allow.
			end
		end
		for (int k = 0; k < 48; k++) begin
			p = int'(take_bits(port_w));
			op = take_bits(1) ? op_write : op_read;
			add_row(0, p, op, region(p, int'(take_bits(3))), k, '0, op == op_write, k == 0);
		end
	endtask

	task automatic issue_row(input stim_row_t r);
		logic [data_w-1:0] data;
		exp_rsp_t e;
		data = r.rnd ? take_bits(data_w) : r.data;
		cmd_valid[r.port] = 1'b1;
		cmd_op[r.port] = r.op;
		cmd_payload[r.port] = make_payload(r.op, r.addr, r.tag, data);
		credits[r.port]--;
		issued[r.port]++;
		issued_any = 1'b1;
		if (r.op == op_write) begin
			ref_mem[r.addr] = data;
		end else begin
			e.port = r.port;
			e.tag = r.tag;
			e.data = ref_mem[r.addr];
			exp_q.push_back(e);
		end
	endtask

	// ==========================================================================
	// stimulus, monitor and watchdog
	// ==========================================================================

	initial begin : stimulus
		logic [n_ports-1:0] used;
		logic hold;
		stim_row_t r;
		int row;
		int cycle;
		int total_stalls;
		aresetn = 1'b0;
		cmd_valid = '0;
		for (int i = 0; i < n_ports; i++) begin
			cmd_op[i] = op_read;
			cmd_payload[i] = '0;
			credits[i] = fifo_depth;
			issued[i] = 0;
			returned[i] = 0;
			stalls[i] = 0;
		end
		issued_any = 1'b0;
		rsp_count = 0;
		last_rsp_cycle = 0;
		neg_cycle = 0;
		lfsr = 32'hb151_838c;
		table_ready = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (5) @(posedge aclk);
		#1;
		aresetn = 1'b1;
		row = 0;
		cycle = 0;
		while (row < n_rows) begin
			@(posedge aclk);
			#1;
			cmd_valid = '0;
			used = '0;
			hold = 1'b0;
			while ((row < n_rows) && !hold) begin
				r = table_rows[row];
				if (r.sync && !all_drained()) begin
					hold = 1'b1;
				end else if ((int'(r.cycle) > cycle) || used[r.port]) begin
					hold = 1'b1;
				end else if (credits[r.port] == 0) begin
					stalls[r.port]++; // out of credits, hold the command.
					hold = 1'b1;
				end else begin
					issue_row(r);
					used[r.port] = 1'b1;
					row++;
				end
			end
			cycle++;
		end
		@(posedge aclk);
		#1;
		cmd_valid = '0;
		while (exp_q.size() != 0) begin
			@(posedge aclk);
		end
		// queues hold at most n_ports * fifo_depth entries and one leaves every cycle.
		repeat (n_ports * fifo_depth + 2) @(posedge aclk);
		total_stalls = 0;
		for (int i = 0; i < n_ports; i++) begin
			credits_match($sformatf("credits[%0d]", i), credits[i], fifo_depth);
			credits_match($sformatf("credit_return count[%0d]", i), returned[i], issued[i]);
			total_stalls += stalls[i];
		end
		if (total_stalls == 0) begin
			report_failure("no port ever ran out of credits");
		end
		$display("test passed");
		$finish;
	end

	always @(negedge aclk) begin : monitor
		int idx;
		neg_cycle++;
		if (!issued_any && (credit_return !== '0)) begin
			report_failure("credit_return went high before any command was issued");
		end
		if (!issued_any && (rsp_valid !== 1'b0)) begin
			report_failure("rsp_valid went high before any command was issued");
		end
		if (rsp_valid === 1'b1) begin
			idx = -1;
			for (int i = 0; i < exp_q.size(); i++) begin
				if ((idx < 0) && (exp_q[i].port == rsp_port)) begin
					idx = i; // oldest read of that port.
				end
			end
			if (idx < 0) begin
				report_failure($sformatf("read response for port %0d with no read outstanding",
					rsp_port));
			end
			compare_tag("rsp_tag", rsp_tag, exp_q[idx].tag);
			expect_data("rsp_data", rsp_data, exp_q[idx].data);
			exp_q.delete(idx);
			if (rsp_count < fair_rsps) begin
				verify_port("rsp_port", rsp_port, port_idx_t'(rsp_count % n_ports));
				if ((rsp_count > 0) && (neg_cycle != last_rsp_cycle + 1)) begin
					report_failure("fairness burst responses were not on consecutive cycles");
				end
			end
			last_rsp_cycle = neg_cycle;
			rsp_count++;
		end
		for (int i = 0; i < n_ports; i++) begin
			if (credit_return[i] === 1'b1) begin
				if (credits[i] >= fifo_depth) begin
					report_failure($sformatf("credit_return on port %0d with nothing outstanding",
						i));
				end
				credits[i]++;
				returned[i]++;
			end
		end
	end

	initial begin : watchdog
		wait (table_ready === 1'b1);
		repeat (n_rows * 20 + 100) @(posedge aclk);
		report_failure("watchdog expired before all commands completed");
	end

endmodule

// ==== source/mem_share_top.sv ====
module mem_share_top
	import mem_share_pkg::*;
(
	input logic aclk,
	input logic aresetn,

	// command side, one entry per requester
	input logic [n_ports-1:0] cmd_valid,
	input opcode_e cmd_op [n_ports],
	input cmd_payload_u cmd_payload [n_ports],
	output logic [n_ports-1:0] credit_return,

	// read responses, shared by all requesters
	output logic rsp_valid,
	output port_idx_t rsp_port,
	output logic [tag_w-1:0] rsp_tag,
	output logic [data_w-1:0] rsp_data
);

	logic [n_ports-1:0] head_valid;
	opcode_e head_op [n_ports];
	cmd_payload_u head_payload [n_ports];

	logic [n_ports-1:0] grant;

	logic acc_valid;
	port_idx_t acc_port;
	opcode_e acc_op;
	cmd_payload_u acc_payload;

	// =========================================================================
	// ingress queues
	// =========================================================================

	for (genvar i = 0; i < n_ports; i++) begin : g_ingress
		port_ingress i_ingress (
			.aclk (aclk),
			.aresetn (aresetn),
			.cmd_valid (cmd_valid[i]),
			.cmd_op (cmd_op[i]),
			.cmd_payload (cmd_payload[i]),
			.pop (grant[i]), // a granted head leaves this cycle.
			.head_valid (head_valid[i]),
			.head_op (head_op[i]),
			.head_payload (head_payload[i]),
			.credit_return (credit_return[i])
		);
	end

	// =========================================================================
	// arbitration
	// =========================================================================

	// memory takes a command every cycle, so every grant is consumed.
	rr_arbiter i_arbiter (
		.aclk (aclk),
		.aresetn (aresetn),
		.req (head_valid),
		.grant (grant)
	);

	// one-hot grant to port index.
	always_comb begin
		acc_port = '0;
		for (int i = 0; i < n_ports; i++) begin
			if (grant[i]) begin
				acc_port = port_idx_t'(i);
			end
		end
	end

	assign acc_valid = |grant;
	assign acc_op = head_op[acc_port];
	assign acc_payload = head_payload[acc_port];

	// =========================================================================
	// memory
	// =========================================================================

	shared_ram i_ram (
		.aclk (aclk),
		.aresetn (aresetn),
		.acc_valid (acc_valid),
		.acc_port (acc_port),
		.acc_op (acc_op),
		.acc_payload (acc_payload),
		.rsp_valid (rsp_valid),
		.rsp_port (rsp_port),
		.rsp_tag (rsp_tag),
		.rsp_data (rsp_data)
	);

endmodule

// ==== source/shared_ram.sv ====
module shared_ram
	import mem_share_pkg::*;
(
	input logic aclk,
	input logic aresetn,
	input logic acc_valid,
	input port_idx_t acc_port,
	input opcode_e acc_op,
	input cmd_payload_u acc_payload,
	output logic rsp_valid,
	output port_idx_t rsp_port,
	output logic [tag_w-1:0] rsp_tag,
	output logic [data_w-1:0] rsp_data
);

	logic [data_w-1:0] mem [mem_words];

	logic cmd_valid_q;
	port_idx_t cmd_port_q;
	opcode_e cmd_op_q;
	cmd_payload_u cmd_payload_q;

	logic [addr_w-1:0] mem_addr;
	logic do_write;
	logic do_read;

	// =========================================================================
	// command register
	// =========================================================================

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			cmd_valid_q <= 1'b0;
		end else begin
			cmd_valid_q <= acc_valid;
		end
	end

	always_ff @(posedge aclk) begin
		if (acc_valid) begin
			cmd_port_q <= acc_port;
			cmd_op_q <= acc_op;
			cmd_payload_q <= acc_payload;
		end
	end

	// =========================================================================
	// payload decode
	// =========================================================================

	assign mem_addr = cmd_payload_q.wr_view.addr; // same bits in both views.

	assign do_write = cmd_valid_q && (cmd_op_q == op_write);
	assign do_read = cmd_valid_q && (cmd_op_q == op_read);

	// =========================================================================
	// array and read response
	// =========================================================================

	always_ff @(posedge aclk) begin
		if (do_write) begin
			mem[mem_addr] <= cmd_payload_q.wr_view.data;
		end
	end

	// a read right behind a write to the same word sees the new data.
	always_ff @(posedge aclk) begin
		if (do_read) begin
			rsp_data <= mem[mem_addr];
			rsp_tag <= cmd_payload_q.rd_view.tag;
			rsp_port <= cmd_port_q; // routes the response back.
		end
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= do_read; // writes complete without a response.
		end
	end

endmodule

// ==== source/port_ingress.sv ====
module port_ingress
	import mem_share_pkg::*;
(
	input logic aclk,
	input logic aresetn,
	input logic cmd_valid,
	input opcode_e cmd_op,
	input cmd_payload_u cmd_payload,
	input logic pop,
	output logic head_valid,
	output opcode_e head_op,
	output cmd_payload_u head_payload,
	output logic credit_return
);

	opcode_e op_mem [fifo_depth];
	cmd_payload_u payload_mem [fifo_depth];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;

	// wraps at fifo_depth, which need not be a power of two.
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
		logic [ptr_w-1:0] result;
		if (ptr == ptr_w'(fifo_depth - 1)) begin
			result = '0;
		end else begin
			result = ptr + 1'b1;
		end
		return result;
	endfunction

	// =========================================================================
	// storage
	// =========================================================================

	// requester only sends while it holds a credit, so a slot is always free.
	always_ff @(posedge aclk) begin
		if (cmd_valid) begin
			op_mem[wr_ptr] <= cmd_op;
			payload_mem[wr_ptr] <= cmd_payload;
		end
	end

	assign head_valid = (count != '0);
	assign head_op = op_mem[rd_ptr]; // valid only with head_valid.
	assign head_payload = payload_mem[rd_ptr];

	// =========================================================================
	// pointers and occupancy
	// =========================================================================

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (cmd_valid) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
		end
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			count <= '0;
		end else begin
			case ({cmd_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // idle, or push and pop together.
			endcase
		end
	end

	// =========================================================================
	// credit return
	// =========================================================================

	// one pulse per popped entry, in the cycle after the pop edge.
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			credit_return <= 1'b0;
		end else begin
			credit_return <= pop;
		end
	end

endmodule

// ==== source/rr_arbiter.sv ====
module rr_arbiter
	import mem_share_pkg::*;
(
	input logic aclk,
	input logic aresetn,
	input logic [n_ports-1:0] req,
	output logic [n_ports-1:0] grant
);

	logic [n_ports-1:0] mask; // ports still due a turn this round.
	logic [n_ports-1:0] masked;
	logic [n_ports-1:0] grant_masked;
	logic [n_ports-1:0] grant_plain;
	logic [n_ports-1:0] next_mask;

	// keeps only the lowest set bit.
	function automatic logic [n_ports-1:0] lowest_one(input logic [n_ports-1:0] vec);
		logic [n_ports-1:0] result;
		logic found;
		result = '0;
		found = 1'b0;
		for (int i = 0; i < n_ports; i++) begin
			if (vec[i] && !found) begin
				result[i] = 1'b1;
				found = 1'b1;
			end
		end
		return result;
	endfunction

	// =========================================================================
	// grant
	// =========================================================================

	assign masked = mask & req;
	assign grant_masked = lowest_one(masked);
	assign grant_plain = lowest_one(req); // round is over, start again from 0.
	assign grant = (|masked) ? grant_masked : grant_plain;

	// =========================================================================
	// mask rotation
	// =========================================================================

	// bit i set when the grant lies below i.
	always_comb begin
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < n_ports; i++) begin
			next_mask[i] = seen;
			seen = seen | grant[i];
		end
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			mask <= '1;
		end else if (|grant) begin
			if (|next_mask) begin
				mask <= next_mask;
			end else begin
				mask <= '1; // top port served, open a new round.
			end
		end
	end

endmodule

// ==== source/mem_share_pkg.sv ====
package mem_share_pkg;

	// =========================================================================
	// sizes
	// =========================================================================

	localparam int n_ports = 4; // requesters sharing the memory.
	localparam int fifo_depth = 4; // queue entries, also credits per port.
	localparam int addr_w = 8;
	localparam int data_w = 32;
	localparam int tag_w = 8;
	localparam int mem_words = 256; // one word per address.

	localparam int port_w = $clog2(n_ports);
	localparam int ptr_w = $clog2(fifo_depth);
	localparam int cnt_w = $clog2(fifo_depth + 1); // holds 0 to fifo_depth.
	localparam int pad_w = data_w - tag_w; // unused bits of a read.

	// =========================================================================
	// command types
	// =========================================================================

	typedef enum logic {
		op_read = 1'b0,
		op_write = 1'b1
	} opcode_e;

	typedef logic [port_w-1:0] port_idx_t;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] data;
	} wr_view_t;

	// address sits in the top bits of both views.
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [tag_w-1:0] tag;
		logic [pad_w-1:0] pad;
	} rd_view_t;

	typedef union packed {
		wr_view_t wr_view;
		rd_view_t rd_view;
	} cmd_payload_u;

endpackage
